//--- dv/core_vectors.txt
// program from @00: one instruction word each, pc = 4 * index
// records from @40: tt rr vvvvvvvv = test number, rd (80 = expect halt), value
@00
// test 1: alu, register and immediate forms
FF800093 00300113 002081B3 40208233 4020D2B3 0020D333 0020A3B3
0020B433 0F00C493 4010D513 00411593 07F0F613 002266B3 FFF13713
// test 2: forwarding at distances 1, 2 and 3
06400793 00178813 00278913 010789B3 41298A33
// test 3: store, load, then a load-use add
04000A93 014AA423 008AAB03 016B0BB3
// test 4: bne, beq, blt, bge, bltu, bgeu, jal, jalr; x24 = 1 or 2 must never commit
00011663 00100C13 00200C13 00010663 00700C13
0020C663 00100C13 00200C13 0020D663 00800C93
00116663 00100C13 00200C13 0020F663 00100C13 00200C13
00C00D6F 00100C13 00200C13 014D0DE7 00100C13 00200C13
// test 5: a7 = 10, ecall, then two writes that must never commit
00A00893 00000073 00500E13 00600E93
@40
// test 1
0101FFFFFFF8 010200000003 0103FFFFFFFB 0104FFFFFFF5 0105FFFFFFFF
01061FFFFFFF 010700000001 010800000000 0109FFFFFF08 010AFFFFFFFC
010B00000030 010C00000078 010DFFFFFFF7 010E00000001
// test 2
020F00000064 021000000065 021200000066 0213000000C9 021400000063
// test 3
031500000040 031600000063 0317000000C6
// test 4
041800000007 041900000008 041A000000A0 041B000000AC
// test 5
05110000000A 058000000000

//--- all.f
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_pipe_core.sv
dv/core_checker.sv
dv/core_tb.sv

//--- dv/core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for rv_pipe_core with its program in the vectors file
// instruction memory holds up to 64 words from address 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core_tb;

    localparam int          prog_max     = 64;
    localparam int          drain_cycles = 10;  // window for late commits
    localparam logic [31:0] nop_word     = 32'h00000013;

    logic                              clk;
    logic                              reset;
    logic [rv_isa_pkg::xlen-1:0]       imem_addr;
    logic [rv_isa_pkg::xlen-1:0]       imem_data;
    logic                              wb_valid;
    logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd;
    logic [rv_isa_pkg::xlen-1:0]       wb_data;
    logic                              is_halted;
    logic                              done;
    logic [15:0]                       failures;
    logic [47:0]                       vec [128];
    int                                prog_words;
    int                                limit;
    int                                cycles;

    rv_pipe_core rv_pipe_core_i (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .is_halted (is_halted)
    );

    core_checker checker_i (
        .clk       (clk),
        .reset     (reset),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .is_halted (is_halted),
        .done      (done),
        .failures  (failures)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] imem_read(input logic [31:0] addr);
        if (addr[31:2] < prog_words)
            return vec[addr[31:2]][31:0];
        return nop_word;  // past the program
    endfunction

    // word for the pc that the last edge produced
    always @(posedge clk) begin
        #1;
        imem_data = imem_read(imem_addr);
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        imem_data = nop_word;
        $readmemh("dv/core_vectors.txt", vec);
        prog_words = 0;
        while (prog_words < prog_max && !$isunknown(vec[prog_words]))
            prog_words++;
        limit  = 8 * prog_words + 50;
        cycles = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: the processor never halted within %0d cycles", limit);
            checker_i.print_counts();
            $display("Test failed");
        end else begin
            repeat (drain_cycles) @(posedge clk);
            checker_i.print_counts();
            if (failures == 0)
                $display("Test completed successfully");
            else
                $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/core_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compares commits in program order with the records
// a record with rd 80 expects the halt and ends the list
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core_checker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wb_valid,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_isa_pkg::xlen-1:0]       wb_data,
    input  logic                              is_halted,
    output logic                              done,
    output logic [15:0]                       failures
);

    localparam int         rec_base  = 64;   // records start at @40
    localparam int         max_recs  = 64;
    localparam logic [7:0] halt_flag = 8'h80;

    logic [47:0] vec [128];
    int          rec_count;
    int          next_rec;
    int          tests_run;
    int          tests_failed;
    logic        test_bad;
    logic        halt_seen;

    function automatic string test_name(input logic [7:0] num);
        case (num)
            8'd1:    return "alu";
            8'd2:    return "forwarding";
            8'd3:    return "memory";
            8'd4:    return "control_flow";
            8'd5:    return "halt";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [7:0] rec_test(input int idx);
        return vec[rec_base + idx][47:40];
    endfunction

    function automatic logic [7:0] rec_rd(input int idx);
        return vec[rec_base + idx][39:32];
    endfunction

    // closes the test when the record just used was its last
    task automatic step_record();
        logic [7:0] num;
        num = rec_test(next_rec);
        next_rec++;
        if (next_rec >= rec_count || rec_test(next_rec) != num) begin
            tests_run++;
            if (test_bad) begin
                tests_failed++;
                $display("test %0d %s: FAIL", num, test_name(num));
            end else begin
                $display("test %0d %s: pass", num, test_name(num));
            end
            test_bad = 1'b0;
        end
    endtask

    task automatic check_commit();
        logic [rv_isa_pkg::xlen-1:0] exp_val;
        logic [7:0]                  num;
        if (halt_seen) begin
            $display("commit to x%0d (%h) seen after the halt", wb_rd, wb_data);
            failures++;
        end else if (next_rec >= rec_count || rec_rd(next_rec) == halt_flag) begin
            $display("unexpected commit to x%0d (%h) where the halt was due",
                     wb_rd, wb_data);
            failures++;
            test_bad = 1'b1;
        end else begin
            exp_val = vec[rec_base + next_rec][31:0];
            num     = rec_test(next_rec);
            if ({3'b000, wb_rd} != rec_rd(next_rec) || wb_data !== exp_val) begin
                $display("error: test %s expected x%0d=%h actual x%0d=%h",
                         test_name(num), rec_rd(next_rec), exp_val, wb_rd, wb_data);
                failures++;
                test_bad = 1'b1;
            end
            step_record();
        end
    endtask

    task automatic check_halt();
        halt_seen = 1'b1;
        while (next_rec < rec_count && rec_rd(next_rec) != halt_flag) begin
            $display("missing commit: test %s never wrote x%0d before the halt",
                     test_name(rec_test(next_rec)), rec_rd(next_rec));
            failures++;
            test_bad = 1'b1;
            step_record();
        end
        if (next_rec < rec_count)
            step_record();  // the halt record
        done = 1'b1;
    endtask

    task print_counts();
        $display("tests run %0d, tests failed %0d, check failures %0d",
                 tests_run, tests_failed, failures);
    endtask

    initial begin
        done         = 1'b0;
        failures     = '0;
        next_rec     = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_bad     = 1'b0;
        halt_seen    = 1'b0;
        $readmemh("dv/core_vectors.txt", vec);
        rec_count = 0;
        while (rec_count < max_recs && rec_rd(rec_count) !== halt_flag)
            rec_count++;
        if (rec_count == max_recs) begin
            $display("the vectors file holds no halt record");
            failures++;
        end else begin
            rec_count++;  // halt record counts too
        end
    end

    // outputs move on the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        if (!reset) begin
            if (halt_seen && !is_halted) begin
                $display("is_halted dropped again after the halt");
                failures++;
            end
            if (wb_valid)
                check_commit();
            if (is_halted && !halt_seen)
                check_halt();
        end
    end

endmodule

//--- design/rv_pipe_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five-stage RV32I subset core, instruction memory outside
// wb_valid pulses once per committed register write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rv_pipe_core (
    input  logic                              clk,
    input  logic                              reset,
    output logic [rv_isa_pkg::xlen-1:0]       imem_addr,
    input  logic [rv_isa_pkg::xlen-1:0]       imem_data,
    output logic                              wb_valid,
    output logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_isa_pkg::xlen-1:0]       wb_data,
    output logic                              is_halted
);

    pipe_pkg::if_id_t            if_id;
    pipe_pkg::id_ex_t            id_ex;
    pipe_pkg::ex_mem_t           ex_mem;
    pipe_pkg::mem_wb_t           mem_wb;
    pipe_pkg::wb_t               wb;
    logic                        stall;
    logic                        redirect;
    logic [rv_isa_pkg::xlen-1:0] redirect_pc;

    // x0 writes are not commits
    assign wb.valid = mem_wb.reg_write && mem_wb.rd != '0;
    assign wb.rd    = mem_wb.rd;
    assign wb.data  = mem_wb.result;

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

    fetch_stage fetch_i (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .if_id       (if_id)
    );

    decode_stage decode_i (
        .clk           (clk),
        .reset         (reset),
        .if_id         (if_id),
        .redirect      (redirect),
        .wb            (wb),
        .ex_rd         (id_ex.rd),
        .ex_mem_read   (id_ex.ctrl.mem_read),
        .ex_reg_write  (id_ex.ctrl.reg_write),
        .mem_rd        (ex_mem.rd),
        .mem_reg_write (ex_mem.ctrl.reg_write),
        .stall         (stall),
        .id_ex         (id_ex)
    );

    execute_stage execute_i (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .wb          (wb),
        .ex_mem      (ex_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage memory_i (
        .clk       (clk),
        .reset     (reset),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .is_halted (is_halted)
    );

endmodule

//--- design/memory_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-cycle word data memory and result select
// low address bits ignored, address wraps at dmem_words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module memory_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::mem_wb_t mem_wb,
    output logic              is_halted
);

    logic [rv_isa_pkg::xlen-1:0]               dmem [rv_isa_pkg::dmem_words];
    logic [$clog2(rv_isa_pkg::dmem_words)-1:0] word_idx;
    logic [rv_isa_pkg::xlen-1:0]               result;
    logic                                      halt_seen;

    assign word_idx = ex_mem.alu_out[2 +: $clog2(rv_isa_pkg::dmem_words)];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < rv_isa_pkg::dmem_words; k++)
                dmem[k] <= '0;
        end else if (ex_mem.ctrl.mem_write && !is_halted) begin
            dmem[word_idx] <= ex_mem.store_data;
        end
    end

    always_comb begin
        if (ex_mem.ctrl.mem_to_reg)     result = dmem[word_idx];
        else if (ex_mem.ctrl.pc_to_reg) result = ex_mem.link;
        else                            result = ex_mem.alu_out;
    end

    // younger instructions are dropped once the ecall is in write-back
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.reg_write <= 1'b0;
            mem_wb.halt      <= 1'b0;
            halt_seen        <= 1'b0;
        end else begin
            mem_wb.reg_write <= ex_mem.ctrl.reg_write && !is_halted;
            mem_wb.halt      <= ex_mem.ctrl.halt;
            halt_seen        <= is_halted;  // sticky
        end
        mem_wb.rd     <= ex_mem.rd;
        mem_wb.result <= result;
    end

    assign is_halted = mem_wb.halt || halt_seen;

endmodule

//--- design/execute_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// forwarding, ALU and branch resolution
// loads are never forwarded from ex/mem, decode stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module execute_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  pipe_pkg::id_ex_t            id_ex,
    input  pipe_pkg::wb_t               wb,
    output pipe_pkg::ex_mem_t           ex_mem,
    output logic                        redirect,
    output logic [rv_isa_pkg::xlen-1:0] redirect_pc
);

    logic [rv_isa_pkg::xlen-1:0] mem_fwd;
    logic [rv_isa_pkg::xlen-1:0] src_a;
    logic [rv_isa_pkg::xlen-1:0] rs2_val;
    logic [rv_isa_pkg::xlen-1:0] src_b;
    logic [rv_isa_pkg::xlen-1:0] alu_out;
    logic                        take;

    assign mem_fwd = ex_mem.ctrl.pc_to_reg ? ex_mem.link : ex_mem.alu_out;

    // newest producer wins
    function automatic logic [rv_isa_pkg::xlen-1:0] pick(
        input logic [rv_isa_pkg::reg_addr_w-1:0] idx,
        input logic [rv_isa_pkg::xlen-1:0]       rdata
    );
        if (idx != '0 && ex_mem.ctrl.reg_write && ex_mem.rd == idx)
            return mem_fwd;
        if (wb.valid && wb.rd == idx)
            return wb.data;
        return rdata;
    endfunction

    always_comb begin
        src_a   = pick(id_ex.rs1, id_ex.rs1_data);
        rs2_val = pick(id_ex.rs2, id_ex.rs2_data);
    end

    assign src_b = id_ex.ctrl.alu_src ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            pipe_pkg::alu_sub:  alu_out = src_a - src_b;
            pipe_pkg::alu_sll:  alu_out = src_a << src_b[4:0];
            pipe_pkg::alu_slt:  alu_out = {31'd0, $signed(src_a) < $signed(src_b)};
            pipe_pkg::alu_sltu: alu_out = {31'd0, src_a < src_b};
            pipe_pkg::alu_xor:  alu_out = src_a ^ src_b;
            pipe_pkg::alu_srl:  alu_out = src_a >> src_b[4:0];
            pipe_pkg::alu_sra:  alu_out = $signed(src_a) >>> src_b[4:0];
            pipe_pkg::alu_or:   alu_out = src_a | src_b;
            pipe_pkg::alu_and:  alu_out = src_a & src_b;
            default:            alu_out = src_a + src_b;
        endcase
    end

    // branch condition by funct3
    always_comb begin
        case (id_ex.funct3)
            3'b000:  take = (src_a == rs2_val);
            3'b001:  take = (src_a != rs2_val);
            3'b100:  take = ($signed(src_a) < $signed(rs2_val));
            3'b101:  take = ($signed(src_a) >= $signed(rs2_val));
            3'b110:  take = (src_a < rs2_val);
            3'b111:  take = (src_a >= rs2_val);
            default: take = 1'b0;
        endcase
    end

    assign redirect    = (id_ex.ctrl.branch && take) || id_ex.ctrl.is_jal
                      || id_ex.ctrl.is_jalr;
    assign redirect_pc = id_ex.ctrl.is_jalr ? (alu_out & ~32'd1)
                                            : id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (reset)
            ex_mem.ctrl <= '0;
        else
            ex_mem.ctrl <= id_ex.ctrl;
        ex_mem.alu_out    <= alu_out;
        ex_mem.store_data <= rs2_val;
        ex_mem.link       <= id_ex.pc + 32'd4;
        ex_mem.rd         <= id_ex.rd;
    end

endmodule

//--- design/decode_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control decode, immediates and register file
// write-back data passes through to same-cycle reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module decode_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  pipe_pkg::if_id_t                  if_id,
    input  logic                              redirect,
    input  pipe_pkg::wb_t                     wb,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] ex_rd,
    input  logic                              ex_mem_read,
    input  logic                              ex_reg_write,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                              mem_reg_write,
    output logic                              stall,
    output pipe_pkg::id_ex_t                  id_ex
);

    rv_isa_pkg::inst_t                 inst;
    logic [6:0]                        opcode;
    logic                              is_ecall;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs1_idx;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs2_idx;
    logic [rv_isa_pkg::xlen-1:0]       rs1_data;
    logic [rv_isa_pkg::xlen-1:0]       rs2_data;
    logic [rv_isa_pkg::xlen-1:0]       imm;
    logic [rv_isa_pkg::xlen-1:0]       regs [32];
    pipe_pkg::alu_op_t                 alu_fn;
    pipe_pkg::ctrl_t                   ctrl;
    logic                              uses_rs1;
    logic                              uses_rs2;
    logic                              load_use;
    logic                              a7_busy;

    assign inst     = if_id.inst;
    assign opcode   = inst.r.opcode;
    assign is_ecall = (opcode == rv_isa_pkg::op_system);
    assign rs1_idx  = is_ecall ? rv_isa_pkg::ecall_arg_reg : inst.r.rs1;
    assign rs2_idx  = inst.r.rs2;

    // register file, x0 is hardwired
    always_ff @(posedge clk) begin
        if (wb.valid)
            regs[wb.rd] <= wb.data;
    end

    always_comb begin
        if (rs1_idx == '0)                         rs1_data = '0;
        else if (wb.valid && wb.rd == rs1_idx)     rs1_data = wb.data;
        else                                       rs1_data = regs[rs1_idx];
        if (rs2_idx == '0)                         rs2_data = '0;
        else if (wb.valid && wb.rd == rs2_idx)     rs2_data = wb.data;
        else                                       rs2_data = regs[rs2_idx];
    end

    // same word, read per format
    always_comb begin
        case (opcode)
            rv_isa_pkg::op_store:
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            rv_isa_pkg::op_branch:
                imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            rv_isa_pkg::op_jal:
                imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                       inst.j.imm11, inst.j.imm10_1, 1'b0};
            default:
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
        endcase
    end

    always_comb begin
        case (inst.r.funct3)
            3'd0:    alu_fn = (opcode == rv_isa_pkg::op_rtype && inst.r.funct7[5])
                              ? pipe_pkg::alu_sub : pipe_pkg::alu_add;
            3'd1:    alu_fn = pipe_pkg::alu_sll;
            3'd2:    alu_fn = pipe_pkg::alu_slt;
            3'd3:    alu_fn = pipe_pkg::alu_sltu;
            3'd4:    alu_fn = pipe_pkg::alu_xor;
            3'd5:    alu_fn = inst.r.funct7[5] ? pipe_pkg::alu_sra : pipe_pkg::alu_srl;
            3'd6:    alu_fn = pipe_pkg::alu_or;
            default: alu_fn = pipe_pkg::alu_and;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            rv_isa_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_fn;
            end
            rv_isa_pkg::op_itype: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_fn;
            end
            rv_isa_pkg::op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            rv_isa_pkg::op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            rv_isa_pkg::op_branch: ctrl.branch = 1'b1;
            rv_isa_pkg::op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.pc_to_reg = 1'b1;
            end
            rv_isa_pkg::op_jalr: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jalr   = 1'b1;
                ctrl.pc_to_reg = 1'b1;
                ctrl.alu_src   = 1'b1;  // rs1 + imm
            end
            rv_isa_pkg::op_system: ctrl.halt = (rs1_data == rv_isa_pkg::halt_code);
            default: ;
        endcase
    end

    // hazards against the instructions in execute and memory
    assign uses_rs1 = (opcode != rv_isa_pkg::op_jal);
    assign uses_rs2 = (opcode == rv_isa_pkg::op_rtype) || (opcode == rv_isa_pkg::op_store)
                   || (opcode == rv_isa_pkg::op_branch);
    assign load_use = ex_mem_read && ex_rd != '0
                   && ((uses_rs1 && ex_rd == rs1_idx) || (uses_rs2 && ex_rd == rs2_idx));
    assign a7_busy  = is_ecall
                   && ((ex_reg_write && ex_rd == rv_isa_pkg::ecall_arg_reg)
                    || (mem_reg_write && mem_rd == rv_isa_pkg::ecall_arg_reg));
    assign stall    = load_use || a7_busy;

    always_ff @(posedge clk) begin
        if (reset || redirect || stall)
            id_ex.ctrl <= '0;  // bubble
        else
            id_ex.ctrl <= ctrl;
        id_ex.pc       <= if_id.pc;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
        id_ex.rs1      <= rs1_idx;
        id_ex.rs2      <= rs2_idx;
        id_ex.rd       <= inst.r.rd;
        id_ex.funct3   <= inst.r.funct3;
    end

endmodule

//--- design/fetch_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pc and fetch/decode register, always predicts pc+4
// imem_data must be valid in the cycle of imem_addr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fetch_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [rv_isa_pkg::xlen-1:0] redirect_pc,
    input  logic [rv_isa_pkg::xlen-1:0] imem_data,
    output logic [rv_isa_pkg::xlen-1:0] imem_addr,
    output pipe_pkg::if_id_t            if_id
);

    logic [rv_isa_pkg::xlen-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= '0;
            if_id <= '0;  // zero word decodes as nop
        end else if (redirect) begin
            // redirect beats stall
            pc    <= redirect_pc;
            if_id <= '0;
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            if_id.inst <= imem_data;
            if_id.pc   <= pc;
        end
    end

endmodule

//--- design/pipe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control word and stage register layouts
// an all-zero ctrl_t is a bubble
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pipe_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;    // second operand is imm
        logic    branch;
        logic    is_jal;
        logic    is_jalr;
        logic    pc_to_reg;  // link write
        logic    halt;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::inst_t               inst;
        logic [rv_isa_pkg::xlen-1:0]     pc;
    } if_id_t;

    typedef struct packed {
        ctrl_t                             ctrl;
        logic [rv_isa_pkg::xlen-1:0]       pc;
        logic [rv_isa_pkg::xlen-1:0]       rs1_data;
        logic [rv_isa_pkg::xlen-1:0]       rs2_data;
        logic [rv_isa_pkg::xlen-1:0]       imm;
        logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
        logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
        logic [2:0]                        funct3;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                             ctrl;
        logic [rv_isa_pkg::xlen-1:0]       alu_out;
        logic [rv_isa_pkg::xlen-1:0]       store_data;
        logic [rv_isa_pkg::xlen-1:0]       link;
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                              reg_write;
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
        logic [rv_isa_pkg::xlen-1:0]       result;
        logic                              halt;
    } mem_wb_t;

    typedef struct packed {
        logic                              valid;  // never set for x0
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
        logic [rv_isa_pkg::xlen-1:0]       data;
    } wb_t;

endpackage

//--- design/rv_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I subset encodings and instruction field layouts
// no lui/auipc, no byte or halfword memory access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv_isa_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned dmem_words = 256;  // word addressed

    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_system = 7'b1110011;

    // ecall halts only when a7 holds 10
    localparam logic [reg_addr_w-1:0] ecall_arg_reg = 5'd17;
    localparam logic [xlen-1:0]       halt_code     = 32'd10;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
    } inst_t;

endpackage
